// ==== common/seg_format_pkg.sv ====
`default_nettype none

package seg_format_pkg;

    // ----------------------------------------
    // Input word
    // ----------------------------------------

    // Value captured on update.
    localparam int value_width = 32;

    // ----------------------------------------
    // Display digits
    // ----------------------------------------

    // One hex nibble or one BCD digit.
    localparam int digit_width = 4;

    // 2^32 - 1 has ten decimal digits.
    localparam int bcd_digits = 10;

    // ----------------------------------------
    // Base select encoding
    // ----------------------------------------

    localparam logic base_hex = 1'b0;  // Nibbles of value.
    localparam logic base_dec = 1'b1;  // Converted BCD digits.

endpackage : seg_format_pkg

`default_nettype wire

// ==== common/seg_display_pkg.sv ====
`default_nettype none

package seg_display_pkg;

    // ----------------------------------------
    // Display geometry
    // ----------------------------------------

    localparam int num_digits  = 8;
    localparam int bank_digits = 4;  // Digits 0..3 on sseg, 4..7 on sseg1.

    // Bits 6..0 are segments a..g, bit 7 is the decimal point.
    localparam int seg_width = 8;

    localparam logic [seg_width-1:0] seg_blank = '0;

    // ----------------------------------------
    // Segment patterns, active high
    // ----------------------------------------

    function automatic logic [seg_width-1:0] seg_pattern(input logic [3:0] digit);
        logic [6:0] segs;  // Order a..g.
        case (digit)
            4'h0:    segs = 7'b111_1110;
            4'h1:    segs = 7'b011_0000;
            4'h2:    segs = 7'b110_1101;
            4'h3:    segs = 7'b111_1001;
            4'h4:    segs = 7'b011_0011;
            4'h5:    segs = 7'b101_1011;
            4'h6:    segs = 7'b101_1111;
            4'h7:    segs = 7'b111_0000;
            4'h8:    segs = 7'b111_1111;
            4'h9:    segs = 7'b111_1011;
            4'hA:    segs = 7'b111_0111;
            4'hB:    segs = 7'b001_1111;
            4'hC:    segs = 7'b100_1110;
            4'hD:    segs = 7'b011_1101;
            4'hE:    segs = 7'b100_1111;
            4'hF:    segs = 7'b100_0111;
            default: segs = 7'b000_0001;
        endcase
        // Decimal point stays dark.
        return {1'b0, segs};
    endfunction

endpackage : seg_display_pkg

`default_nettype wire

// ==== design/bin_to_bcd.sv ====
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd
    import seg_format_pkg::*;
(
    input  wire                                clk,
    input  wire                                rstn,
    input  wire                                start,
    input  wire  [value_width-1:0]             bin,
    output logic                               done,
    output logic [bcd_digits*digit_width-1:0]  bcd
);

    localparam int bcd_width = bcd_digits * digit_width;
    localparam int cnt_width = $clog2(value_width);

    logic                   running;
    logic [cnt_width-1:0]   shift_cnt;
    logic [value_width-1:0] sreg;       // Binary bits still to shift in.
    logic [value_width-1:0] bin_src;
    logic [bcd_width-1:0]   bcd_src;
    logic [bcd_width-1:0]   bcd_adj;

    function automatic logic [digit_width-1:0] add3(input logic [digit_width-1:0] d);
        if (d >= digit_width'(5)) begin
            return d + digit_width'(3);
        end
        return d;
    endfunction

    // ----------------------------------------
    // Add-three correction
    // ----------------------------------------

    // A start begins from an empty accumulator and the fresh input word.
    always_comb begin
        bcd_src = start ? '0 : bcd;
        bin_src = start ? bin : sreg;
        for (int i = 0; i < bcd_digits; i++) begin
            bcd_adj[i*digit_width +: digit_width] = add3(bcd_src[i*digit_width +: digit_width]);
        end
    end

    // ----------------------------------------
    // Shift control
    // ----------------------------------------

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            running   <= 1'b0;
            shift_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running   <= 1'b1;
                shift_cnt <= cnt_width'(1);  // First shift happens on the start edge.
            end else if (running) begin
                shift_cnt <= shift_cnt + cnt_width'(1);
                if (shift_cnt == cnt_width'(value_width - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Datapath, MSB of the binary word enters the BCD LSB.
    always_ff @(posedge clk) begin
        if (start || running) begin
            bcd  <= {bcd_adj[bcd_width-2:0], bin_src[value_width-1]};
            sreg <= {bin_src[value_width-2:0], 1'b0};
        end
    end

endmodule : bin_to_bcd

`default_nettype wire

// ==== design/digit_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module digit_source
    import seg_format_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    input  wire  [value_width-1:0] value,
    input  wire                    base,
    input  wire                    update,
    output logic                   busy,
    output logic                   load,
    output logic [value_width-1:0] digits
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_conv = 2'd1;
    localparam logic [1:0] st_load = 2'd2;

    logic [1:0]                        state;
    logic                              accept;
    logic                              start;
    logic                              done;
    logic [value_width-1:0]            value_q;
    logic                              base_q;
    logic [bcd_digits*digit_width-1:0] bcd;

    assign accept = update && (state == st_idle);  // Updates while busy are dropped.
    assign busy   = (state != st_idle);

    always_ff @(posedge clk) begin
        if (accept) begin
            value_q <= value;
            base_q  <= base;
        end
    end

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            start <= 1'b0;
            load  <= 1'b0;
        end else begin
            start <= 1'b0;
            load  <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept && (base == base_dec)) begin
                        state <= st_conv;
                        start <= 1'b1;
                    end else if (accept) begin
                        load <= 1'b1;  // Hex needs no conversion.
                    end
                end
                st_conv: begin
                    if (done) begin
                        state <= st_load;
                        load  <= 1'b1;
                    end
                end
                st_load: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Low eight BCD digits, higher ones wrap away.
    assign digits = (base_q == base_hex) ? value_q : bcd[value_width-1:0];

    bin_to_bcd bin_to_bcd_inst (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .bin   (value_q),
        .done  (done),
        .bcd   (bcd)
    );

endmodule : digit_source

`default_nettype wire

// ==== design/digit_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module digit_buffer
    import seg_format_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    load,
    input  wire  [value_width-1:0] digits,
    output logic [value_width-1:0] shown
);

    // ----------------------------------------
    // Displayed digit set
    // ----------------------------------------

    // The scan reads this register only, so a conversion in flight
    // never reaches the display half done.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shown <= '0;  // Display reads 00000000.
        end else if (load) begin
            shown <= digits;
        end
    end

endmodule : digit_buffer

`default_nettype wire

// ==== seg_scan/seg_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_scan
    import seg_format_pkg::*;
    import seg_display_pkg::*;
#(
    parameter logic [15:0] clk_div = 16'd50000
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire  [num_digits*digit_width-1:0] shown,
    output logic [num_digits-1:0]            digit_en,
    output logic [seg_width-1:0]             sseg,
    output logic [seg_width-1:0]             sseg1
);

    localparam int sel_width = $clog2(num_digits);

    logic [15:0]            div_cnt;
    logic [sel_width-1:0]   digit_sel;
    logic [digit_width-1:0] digit_data;
    logic [seg_width-1:0]   pattern;

    // ----------------------------------------
    // Scan rate divider
    // ----------------------------------------

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_cnt   <= '0;
            digit_sel <= '0;
        end else if (div_cnt == clk_div) begin
            div_cnt   <= '0;
            digit_sel <= digit_sel + sel_width'(1);  // Wraps 7 -> 0.
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

    // ----------------------------------------
    // Digit select and encoding
    // ----------------------------------------

    assign digit_data = shown[digit_sel*digit_width +: digit_width];
    assign pattern    = seg_pattern(digit_data);

    // Enables and both banks change on the same edge.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            digit_en <= '0;
            sseg     <= seg_blank;
            sseg1    <= seg_blank;
        end else begin
            digit_en <= {{(num_digits-1){1'b0}}, 1'b1} << digit_sel;
            if (digit_sel < bank_digits) begin
                sseg  <= pattern;
                sseg1 <= seg_blank;  // Idle bank dark.
            end else begin
                sseg  <= seg_blank;
                sseg1 <= pattern;
            end
        end
    end

endmodule : seg_scan

`default_nettype wire

// ==== design/seg_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_display_top
    import seg_format_pkg::*;
    import seg_display_pkg::*;
#(
    parameter logic [15:0] clk_div = 16'd50000
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire  [value_width-1:0] value,
    input  wire                    base,
    input  wire                    update,
    output logic                   busy,
    output logic [num_digits-1:0]  digit_en,
    output logic [seg_width-1:0]   sseg,
    output logic [seg_width-1:0]   sseg1
);

    logic                   load;
    logic [value_width-1:0] digits;
    logic [value_width-1:0] shown;

    // ----------------------------------------
    // Producer, holding register, scan
    // ----------------------------------------

    digit_source digit_source_inst (
        .clk    (clk),
        .rstn   (rstn),
        .value  (value),
        .base   (base),
        .update (update),
        .busy   (busy),
        .load   (load),
        .digits (digits)
    );

    digit_buffer digit_buffer_inst (
        .clk    (clk),
        .rstn   (rstn),
        .load   (load),
        .digits (digits),
        .shown  (shown)
    );

    seg_scan #(
        .clk_div (clk_div)
    ) seg_scan_inst (
        .clk      (clk),
        .rstn     (rstn),
        .shown    (shown),
        .digit_en (digit_en),
        .sseg     (sseg),
        .sseg1    (sseg1)
    );

endmodule : seg_display_top

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    // Free running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verification/seg_display_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_display_tb
    import seg_format_pkg::*;
    import seg_display_pkg::*;
;

    localparam logic [15:0] tb_clk_div = 16'd3;
    localparam int scan_cycles     = num_digits * (tb_clk_div + 1);
    localparam int change_limit    = 2 * (tb_clk_div + 1);
    localparam int conv_limit      = 35 + 10;
    localparam int num_tests       = 20;  // Updates plus the long scan.
    localparam int cycles_per_test = 35 + scan_cycles + 40;
    localparam int cycle_limit     = num_tests * cycles_per_test;

    logic                   clk;
    logic                   rstn;
    logic [value_width-1:0] value;
    logic                   base;
    logic                   update;
    logic                   busy;
    logic [num_digits-1:0]  digit_en;
    logic [seg_width-1:0]   sseg;
    logic [seg_width-1:0]   sseg1;

    logic [value_width-1:0] expected_shown = '0;
    logic [num_digits-1:0]  last_en = '0;
    integer                 seed;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycle_count = 0;

    tb_clk_gen #(.period_ns(40)) tb_clk_gen_inst (.clk(clk));

    seg_display_top #(
        .clk_div (tb_clk_div)
    ) seg_display_top_inst (
        .clk      (clk),
        .rstn     (rstn),
        .value    (value),
        .base     (base),
        .update   (update),
        .busy     (busy),
        .digit_en (digit_en),
        .sseg     (sseg),
        .sseg1    (sseg1)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Segments a..g in bits 6..0, point dark.
    function automatic logic [seg_width-1:0] segment_code(input logic [3:0] d);
        case (d)
            4'h0: return 8'h7E;
            4'h1: return 8'h30;
            4'h2: return 8'h6D;
            4'h3: return 8'h79;
            4'h4: return 8'h33;
            4'h5: return 8'h5B;
            4'h6: return 8'h5F;
            4'h7: return 8'h70;
            4'h8: return 8'h7F;
            4'h9: return 8'h7B;
            4'hA: return 8'h77;
            4'hB: return 8'h1F;
            4'hC: return 8'h4E;
            4'hD: return 8'h3D;
            4'hE: return 8'h4F;
            4'hF: return 8'h47;
            default: return 8'h00;
        endcase
    endfunction

    // Eight divisions by ten, so anything above 10^8 wraps.
    function automatic logic [value_width-1:0] decimal_digits(input logic [value_width-1:0] v);
        logic [value_width-1:0] rest;
        logic [value_width-1:0] result;
        rest   = v;
        result = '0;
        for (int i = 0; i < num_digits; i++) begin
            result[i*digit_width +: digit_width] = 4'(rest % 10);
            rest = rest / 10;
        end
        return result;
    endfunction

    // ----------------------------------------
    // Stimulus and monitor
    // ----------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got == want) else begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic pulse_update(input logic [value_width-1:0] v, input logic b);
        next_cycle();
        value  = v;
        base   = b;
        update = 1'b1;
        next_cycle();
        update = 1'b0;
    endtask

    // Returns on the negedge after the buffer took the new digits.
    task automatic wait_loaded(input logic b);
        int waited;
        waited = 0;
        if (b == base_hex) begin
            next_cycle();  // Load edge.
            @(negedge clk);
            expect_value("busy", busy, 1'b0);
        end else begin
            @(negedge clk);
            expect_value("busy", busy, 1'b1);
            while (busy && waited < conv_limit) begin
                @(negedge clk);
                waited++;
            end
            assert (!busy) else begin
                errors++;
                $display("busy stayed high for %0d cycles after an update", conv_limit);
            end
        end
        last_en = digit_en;
    endtask

    task automatic check_digit();
        int                   pos;
        logic [seg_width-1:0] want;
        logic [num_digits-1:0] next_en;
        pos = 0;
        checks++;
        for (int i = 0; i < num_digits; i++) begin
            if (digit_en[i]) begin
                pos = i;
            end
        end
        assert ($onehot(digit_en)) else begin
            errors++;
            $display("mismatch digit_en: got %h, not one-hot", digit_en);
        end
        if (last_en != '0) begin
            next_en = {last_en[num_digits-2:0], last_en[num_digits-1]};  // Next digit up.
            expect_value("digit_en", digit_en, next_en);
        end
        want = segment_code(expected_shown[pos*digit_width +: digit_width]);
        if (pos < bank_digits) begin
            expect_value("sseg", sseg, want);
            expect_value("sseg1", sseg1, 8'h00);
        end else begin
            expect_value("sseg", sseg, 8'h00);
            expect_value("sseg1", sseg1, want);
        end
        last_en = digit_en;
    endtask

    task automatic check_scan(input int changes);
        int seen;
        int idle;
        seen = 0;
        while (seen < changes) begin
            idle = 0;
            @(negedge clk);
            while (digit_en == last_en && idle < change_limit) begin
                @(negedge clk);
                idle++;
            end
            assert (digit_en != last_en) else begin
                errors++;
                $display("digit_en did not move for %0d cycles", change_limit);
                return;
            end
            check_digit();
            seen++;
        end
    endtask

    task automatic show_and_expect(input logic [value_width-1:0] v, input logic b,
                                   input logic [value_width-1:0] want);
        pulse_update(v, b);
        wait_loaded(b);
        expected_shown = want;
        check_scan(num_digits);
    endtask

    task automatic show_value(input logic [value_width-1:0] v, input logic b);
        show_and_expect(v, b, (b == base_dec) ? decimal_digits(v) : v);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        expect_value("digit_en", digit_en, 8'h00);
        expect_value("sseg", sseg, 8'h00);
        expect_value("sseg1", sseg1, 8'h00);
        expect_value("busy", busy, 1'b0);
        next_cycle();
        rstn = 1'b1;
        @(negedge clk);
        last_en = digit_en;
        check_scan(num_digits);  // Buffer still all zeros.
    endtask

    task automatic test_hex();
        show_value(32'h89AB_CDEF, base_hex);
        repeat (4) begin
            show_value($random(seed), base_hex);
        end
    endtask

    task automatic test_decimal();
        logic [value_width-1:0] r;
        show_value(32'd0, base_dec);
        show_value(32'd12345678, base_dec);
        repeat (4) begin
            r = $random(seed);
            show_value(r % 100000000, base_dec);
        end
    endtask

    task automatic test_overflow();
        logic [value_width-1:0] r;
        show_and_expect(32'hFFFF_FFFF, base_dec, 32'h9496_7295);
        repeat (2) begin
            r     = $random(seed);
            r[31] = 1'b1;  // Well above 10^8.
            show_value(r, base_dec);
        end
    endtask

    task automatic test_dropped_update();
        pulse_update(32'd87654321, base_dec);
        pulse_update(32'd11111111, base_dec);  // Lands while busy.
        wait_loaded(base_dec);
        expected_shown = decimal_digits(32'd87654321);
        check_scan(num_digits);
        expect_value("busy", busy, 1'b0);
    endtask

    task automatic test_scan_order();
        show_value(32'h7654_3210, base_hex);
        check_scan(2 * num_digits);
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed   = 32'h0e93_2c5d;
        rstn   = 1'b0;
        value  = '0;
        base   = base_hex;
        update = 1'b0;
        test_reset();
        test_hex();
        test_decimal();
        test_overflow();
        test_dropped_update();
        test_scan_order();
        $display("digit checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : seg_display_tb

`default_nettype wire

// ==== seg_display_top.f ====
common/seg_format_pkg.sv
common/seg_display_pkg.sv
design/bin_to_bcd.sv
design/digit_source.sv
design/digit_buffer.sv
seg_scan/seg_scan.sv
design/seg_display_top.sv
verification/tb_clk_gen.sv
verification/seg_display_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := seg_display_tb
RTL_TOP    := seg_display_top
FILELIST   := seg_display_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := tests failed
PASS_MSG   := all tests passed
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, not the simulator's exit code.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
